// ==== Makefile ====
TOP := system_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f $(wildcard logic/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	-obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/system_props.sv ====
`default_nettype none

module system_props (
    input wire logic       i_clk,
    input wire logic       i_reset,
    input wire logic       i_bus_req,
    input wire logic       i_bus_we,
    input wire logic       i_bus_gnt,
    input wire logic       i_uart_req,
    input wire logic       i_ram_gnt,
    input wire logic       i_uart_gnt,
    input wire logic       i_tmr_gnt,
    input wire logic [1:0] i_uart_state,
    input wire logic       i_uart_tx
);

    a_gnt_after_req: assert property (@(posedge i_clk) disable iff (i_reset)
        i_bus_req |=> i_bus_gnt)
        else $error("bus grant missing one cycle after a request");

    a_gnt_only_after_req: assert property (@(posedge i_clk) disable iff (i_reset)
        i_bus_gnt |-> $past(i_bus_req))
        else $error("bus grant without a request in the previous cycle");

    // State 0 is the idle state of the serializer
    a_tx_idle_until_write: assert property (@(posedge i_clk) disable iff (i_reset)
        ($past(i_uart_state) == 2'd0 && !i_uart_tx) |-> $past(i_uart_req && i_bus_we))
        else $error("UART line left idle without a data write");

    a_one_slave_gnt: assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0({i_ram_gnt, i_uart_gnt, i_tmr_gnt}))
        else $error("more than one slave granted the same access");

endmodule

bind system system_props u_props (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_bus_req    (i_bus_req),
    .i_bus_we     (i_bus_we),
    .i_bus_gnt    (o_bus_gnt),
    .i_uart_req   (uart_req),
    .i_ram_gnt    (ram_gnt),
    .i_uart_gnt   (uart_gnt),
    .i_tmr_gnt    (tmr_gnt),
    .i_uart_state (u_uart.state_q),
    .i_uart_tx    (o_uart_tx)
);

`default_nettype wire

// ==== bench/system_tb.sv ====
`default_nettype none

module system_tb;
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int RAM_WORDS        = 256;
    localparam int CLKS_PER_BIT     = 8;
    localparam int NUM_RAM_OPS      = 400;
    localparam int NUM_UART_BYTES   = 6;
    localparam int NUM_TIMER_ROUNDS = 4;
    localparam int FRAME_CYCLES     = 10 * CLKS_PER_BIT;    // Start, 8 data, stop
    localparam int NUM_TXNS         = RAM_WORDS + NUM_RAM_OPS + 5 * NUM_UART_BYTES
                                      + 3 * NUM_TIMER_ROUNDS;
    localparam int WATCHDOG_CYCLES  = NUM_TXNS * FRAME_CYCLES + 1000;

    logic        clk;
    logic        reset;
    logic        bus_req;
    logic        bus_we;
    size_e       bus_hb;
    addr_t       bus_addr;
    data_t       bus_wdata;
    logic        bus_gnt;
    data_t       bus_rdata;
    logic        uart_tx;
    logic        uart_irq;
    logic        tmr_irq;
    int unsigned cycle_cnt = 0;
    int unsigned errors = 0;
    int unsigned checks = 0;
    logic [7:0]  ram_bytes [RAM_WORDS * 4];           // Byte-level RAM model
    logic [7:0]  exp_bytes [$];                       // Bytes owed on the serial line

    system #(
        .RAM_WORDS    (RAM_WORDS),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_system (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_bus_req   (bus_req),
        .i_bus_we    (bus_we),
        .i_bus_hb    (bus_hb),
        .i_bus_addr  (bus_addr),
        .i_bus_wdata (bus_wdata),
        .o_bus_gnt   (bus_gnt),
        .o_bus_rdata (bus_rdata),
        .o_uart_tx   (uart_tx),
        .o_uart_irq  (uart_irq),
        .o_timer_irq (tmr_irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ###################################################################
    // Checking helpers and the reference model
    // ###################################################################

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic model_write(input logic [1:0] hb, input int unsigned idx,
                               input logic [1:0] off, input data_t data);
        int unsigned base;
        int unsigned half;
        base = idx * 4;
        half = base + (off[1] ? 2 : 0);
        case (hb)
            2'd0: ram_bytes[base + off] = data[7:0];
            2'd1: begin
                ram_bytes[half]     = data[7:0];
                ram_bytes[half + 1] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    ram_bytes[base + i] = data[i*8 +: 8];
                end
            end
        endcase
    endtask

    function automatic data_t model_read(input logic [1:0] hb, input int unsigned idx,
                                         input logic [1:0] off);
        int unsigned base;
        int unsigned half;
        base = idx * 4;
        half = base + (off[1] ? 2 : 0);
        case (hb)
            2'd0:    return {24'd0, ram_bytes[base + off]};
            2'd1:    return {16'd0, ram_bytes[half + 1], ram_bytes[half]};
            default: return {ram_bytes[base + 3], ram_bytes[base + 2],
                             ram_bytes[base + 1], ram_bytes[base]};
        endcase
    endfunction

    function automatic logic [3:0] unmapped_region();
        int unsigned pick;
        pick = $urandom % 10;
        return (pick < 2) ? 4'(pick) : 4'(pick + 6);   // 0, 1 or 8 to 15
    endfunction

    function automatic addr_t periph_addr(input logic [3:0] region);
        return {region, 24'($urandom), 2'b00, 2'($urandom)};    // Register select 0
    endfunction

    // One request, then the grant one cycle later; returns at the grant's negedge
    task automatic bus_access(input logic we, input logic [1:0] hb, input addr_t addr,
                              input data_t wdata, output data_t rdata,
                              output int unsigned stamp);
        @(posedge clk);
        bus_req   <= 1'b1;
        bus_we    <= we;
        bus_hb    <= size_e'(hb);
        bus_addr  <= addr;
        bus_wdata <= wdata;
        @(negedge clk);
        stamp = cycle_cnt;
        if (bus_gnt !== 1'b0) begin
            note_failure("grant raised during the request cycle");
        end
        @(posedge clk);
        bus_req <= 1'b0;
        @(negedge clk);
        if (bus_gnt !== 1'b1) begin
            note_failure("no grant one cycle after the request");
        end
        rdata = bus_rdata;
    endtask

    task automatic wait_irq(input bit from_timer, input int unsigned limit,
                            output int unsigned rise_cycle);
        int unsigned waited;
        waited = 0;
        while ((from_timer ? tmr_irq : uart_irq) !== 1'b1 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        rise_cycle = cycle_cnt;
        if ((from_timer ? tmr_irq : uart_irq) !== 1'b1) begin
            note_failure(from_timer ? "timer interrupt never rose" : "UART interrupt never rose");
        end
    endtask

    // ###################################################################
    // Test sequences
    // ###################################################################

    task automatic fill_ram();
        data_t       rd;
        data_t       wd;
        addr_t       addr;
        int unsigned stamp;
        for (int w = 0; w < RAM_WORDS; w++) begin
            addr = {4'h2 + 4'(w % 2), 26'(w), 2'b00};
            wd   = addr ^ {addr[15:0], addr[31:16]} ^ 32'h6D2B_79F5;
            model_write(2'd2, w, 2'd0, wd);
            bus_access(1'b1, 2'd2, addr, wd, rd, stamp);
        end
    endtask

    task automatic run_ram_traffic();
        data_t       rd;
        data_t       wd;
        addr_t       addr;
        int unsigned stamp;
        int unsigned kind;
        int unsigned idx;
        logic [1:0]  off;
        logic [1:0]  hb;
        for (int op = 0; op < NUM_RAM_OPS; op++) begin
            kind = $urandom % 8;
            idx  = $urandom % RAM_WORDS;
            off  = 2'($urandom);
            hb   = 2'($urandom);                      // 3 counts as a word
            wd   = $urandom;
            if (kind == 0) begin
                addr = {unmapped_region(), 28'($urandom)};
                bus_access(1'($urandom), hb, addr, wd, rd, stamp);
                check_value("o_bus_rdata (unmapped)", rd, 32'd0);
            end else begin
                addr = {4'h2 + 4'($urandom % 2), 26'(idx), off};
                if (kind < 4) begin
                    model_write(hb, idx, off, wd);
                    bus_access(1'b1, hb, addr, wd, rd, stamp);
                end else begin
                    bus_access(1'b0, hb, addr, wd, rd, stamp);
                    check_value("o_bus_rdata (RAM)", rd, model_read(hb, idx, off));
                end
            end
            repeat ($urandom % 3) @(posedge clk);
        end
    endtask

    task automatic run_uart_frames();
        data_t       rd;
        logic [7:0]  tx_byte;
        logic        uart_busy;
        int unsigned stamp;
        int unsigned wstamp;
        int unsigned rise;
        for (int n = 0; n < NUM_UART_BYTES; n++) begin
            bus_access(1'b0, 2'd2, periph_addr(4'h4 + 4'($urandom % 2)), '0, rd, stamp);
            check_value("UART status (idle)", rd, 32'd0);
            uart_busy = rd[UART_ST_BUSY];
            tx_byte   = 8'($urandom);
            if (!uart_busy) begin
                exp_bytes.push_back(tx_byte);
            end
            bus_access(1'b1, 2'd2, periph_addr(4'h4), {24'($urandom), tx_byte}, rd, wstamp);
            bus_access(1'b0, 2'd2, periph_addr(4'h5), '0, rd, stamp);
            check_value("UART status (sending)", rd, 32'd1 << UART_ST_BUSY);
            uart_busy = rd[UART_ST_BUSY];
            tx_byte   = 8'($urandom);
            if (!uart_busy) begin
                exp_bytes.push_back(tx_byte);
            end
            bus_access(1'b1, 2'd2, periph_addr(4'h4), {24'd0, tx_byte}, rd, stamp);
            wait_irq(1'b0, FRAME_CYCLES + 20, rise);
            check_value("o_uart_irq rise cycle", rise, wstamp + FRAME_CYCLES + 1);
            check_value("bytes still owed on o_uart_tx", exp_bytes.size(), 0);
            bus_access(1'b0, 2'd2, periph_addr(4'h4), '0, rd, stamp);
            check_value("UART status (done)", rd, 32'd1 << UART_ST_DONE);
            check_value("o_uart_irq after status read", uart_irq, 1'b0);
        end
    endtask

    task automatic run_timer_rounds();
        data_t       rd;
        int unsigned n;
        int unsigned gap;
        int unsigned wstamp;
        int unsigned rstamp;
        int unsigned rise;
        for (int round = 0; round < NUM_TIMER_ROUNDS; round++) begin
            n = 8 + $urandom % 56;
            bus_access(1'b1, 2'd2, periph_addr(4'h6 + 4'($urandom % 2)), 32'(n), rd, wstamp);
            check_value("o_timer_irq after compare write", tmr_irq, 1'b0);
            gap = $urandom % (n - 6);                 // Read finishes before the match
            repeat (gap) @(posedge clk);
            bus_access(1'b0, 2'd2, periph_addr(4'h7), '0, rd, rstamp);
            check_value("timer count", rd, rstamp - wstamp - 1);
            wait_irq(1'b1, n + 20, rise);
            check_value("o_timer_irq rise cycle", rise, wstamp + n + 1);
            repeat ($urandom % 8) @(posedge clk);
            bus_access(1'b0, 2'd2, periph_addr(4'h6), '0, rd, rstamp);
            check_value("timer count", rd, rstamp - wstamp - 1);
            check_value("o_timer_irq held", tmr_irq, 1'b1);
        end
    endtask

    // ###################################################################
    // Serial line decoder, sampling at mid-bit
    // ###################################################################

    initial begin : serial_monitor
        logic [7:0] rx_byte;
        forever begin
            @(negedge clk);
            if (!reset && uart_tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                check_value("o_uart_tx start bit", uart_tx, 1'b0);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    rx_byte[i] = uart_tx;                 // LSB first
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                check_value("o_uart_tx stop bit", uart_tx, 1'b1);
                if (exp_bytes.size() == 0) begin
                    note_failure("frame on o_uart_tx without a byte written while idle");
                end else begin
                    check_value("decoded UART byte", rx_byte, exp_bytes.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, %0d errors so far",
                 WATCHDOG_CYCLES, errors + 1);
        $display("Errors found");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(39));
        reset     = 1'b1;
        bus_req   = 1'b0;
        bus_we    = 1'b0;
        bus_hb    = SIZE_WORD;
        bus_addr  = '0;
        bus_wdata = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        fill_ram();
        run_ram_traffic();
        run_uart_frames();
        run_timer_rounds();
        check_value("bytes still owed on o_uart_tx", exp_bytes.size(), 0);
        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/bus_decode.sv ====
`default_nettype none

module bus_decode (
    input  wire logic           i_clk,
    input  wire logic           i_reset,
    input  wire logic           i_bus_req,
    input  wire bus_pkg::addr_t i_bus_addr,
    input  wire logic           i_ram_gnt,
    input  wire logic           i_uart_gnt,
    input  wire logic           i_tmr_gnt,
    input  wire bus_pkg::data_t i_ram_rdata,
    input  wire bus_pkg::data_t i_uart_rdata,
    input  wire bus_pkg::data_t i_tmr_rdata,
    output logic                o_ram_req,
    output logic                o_uart_req,
    output logic                o_tmr_req,
    output logic                o_bus_gnt,
    output bus_pkg::data_t      o_bus_rdata
);
    import bus_pkg::*;

    region_e region;
    region_e region_q;                     // Region of the access in flight
    logic    unmapped_req;
    logic    unmapped_gnt_q;

    assign region = region_e'(i_bus_addr[31:28]);

    always_comb begin
        o_ram_req    = 1'b0;
        o_uart_req   = 1'b0;
        o_tmr_req    = 1'b0;
        unmapped_req = 1'b0;
        case (region)
            REGION_RAM_LO, REGION_RAM_HI:   o_ram_req  = i_bus_req;
            REGION_UART_LO, REGION_UART_HI: o_uart_req = i_bus_req;
            REGION_TMR_LO, REGION_TMR_HI:   o_tmr_req  = i_bus_req;
            default:                        unmapped_req = i_bus_req;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_bus_req) begin
            region_q <= region;
        end
    end

    // Nobody else answers a hole in the map, so grant it here
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            unmapped_gnt_q <= 1'b0;
        end else begin
            unmapped_gnt_q <= unmapped_req;
        end
    end

    assign o_bus_gnt = i_ram_gnt | i_uart_gnt | i_tmr_gnt | unmapped_gnt_q;

    always_comb begin
        case (region_q)
            REGION_RAM_LO, REGION_RAM_HI:   o_bus_rdata = i_ram_rdata;
            REGION_UART_LO, REGION_UART_HI: o_bus_rdata = i_uart_rdata;
            REGION_TMR_LO, REGION_TMR_HI:   o_bus_rdata = i_tmr_rdata;
            default:                        o_bus_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // ####################################################################
    // Address map
    // ####################################################################

    typedef enum logic [3:0] {
        REGION_RAM_LO  = 4'h2,
        REGION_RAM_HI  = 4'h3,
        REGION_UART_LO = 4'h4,
        REGION_UART_HI = 4'h5,
        REGION_TMR_LO  = 4'h6,
        REGION_TMR_HI  = 4'h7
    } region_e;                            // Any other nibble is unmapped

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2                   // 2'd3 is also taken as a word
    } size_e;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // ####################################################################
    // Two decodings of the same address word
    // ####################################################################

    typedef struct packed {
        region_e     region;
        logic [25:0] word_idx;
        logic [1:0]  byte_off;
    } mem_view_t;

    typedef struct packed {
        region_e     region;
        logic [23:0] unused_hi;
        logic [1:0]  reg_sel;              // Peripheral register select
        logic [1:0]  unused_lo;
    } reg_view_t;

    typedef union packed {
        mem_view_t mem;                    // RAM view
        reg_view_t regs;                   // Peripheral view
    } bus_addr_u;

endpackage

`default_nettype wire

// ==== logic/data_ram.sv ====
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  wire logic               i_clk,
    input  wire logic               i_reset,
    input  wire logic               i_req,
    input  wire logic               i_we,
    input  wire bus_pkg::size_e     i_hb,
    input  wire bus_pkg::bus_addr_u i_addr,
    input  wire bus_pkg::data_t     i_wdata,
    output logic                    o_gnt,
    output bus_pkg::data_t          o_rdata
);
    import bus_pkg::*;

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    data_t            mem [RAM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic [3:0]       lane_we;
    data_t            wdata_lanes;
    data_t            rword_q;
    logic [1:0]       off_q;
    size_e            size_q;

    assign word_idx = i_addr.mem.word_idx[IDX_W-1:0];

    // Replicate the right-aligned data so every lane sees its field
    always_comb begin
        case (i_hb)
            SIZE_BYTE: begin
                lane_we     = 4'b0001 << i_addr.mem.byte_off;
                wdata_lanes = {4{i_wdata[7:0]}};
            end
            SIZE_HALF: begin
                lane_we     = i_addr.mem.byte_off[1] ? 4'b1100 : 4'b0011;
                wdata_lanes = {2{i_wdata[15:0]}};
            end
            default: begin
                lane_we     = 4'b1111;
                wdata_lanes = i_wdata;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_req) begin
            if (i_we) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (lane_we[lane]) begin
                        mem[word_idx][lane*8 +: 8] <= wdata_lanes[lane*8 +: 8];
                    end
                end
            end
            rword_q <= mem[word_idx];
            off_q   <= i_addr.mem.byte_off;
            size_q  <= i_hb;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_gnt <= 1'b0;
        end else begin
            o_gnt <= i_req;
        end
    end

    always_comb begin
        case (size_q)
            SIZE_BYTE: o_rdata = {24'd0, rword_q[{off_q, 3'b000} +: 8]};
            SIZE_HALF: o_rdata = {16'd0, off_q[1] ? rword_q[31:16] : rword_q[15:0]};
            default:   o_rdata = rword_q;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/interval_timer.sv ====
`default_nettype none

module interval_timer (
    input  wire logic               i_clk,
    input  wire logic               i_reset,
    input  wire logic               i_req,
    input  wire logic               i_we,
    input  wire bus_pkg::bus_addr_u i_addr,
    input  wire bus_pkg::data_t     i_wdata,
    output logic                    o_gnt,
    output bus_pkg::data_t          o_rdata,
    output logic                    o_irq
);
    import bus_pkg::*;
    import periph_pkg::*;

    data_t count_q;
    data_t count_next;
    data_t compare_q;
    data_t compare_next;
    logic  armed_q;
    logic  irq_q;
    logic  compare_wr;
    logic  count_rd;
    logic  match_next;

    assign compare_wr = i_req & i_we & (i_addr.regs.reg_sel == TMR_REG_COMPARE);
    assign count_rd   = i_req & ~i_we & (i_addr.regs.reg_sel == TMR_REG_COUNT);

    always_comb begin
        count_next   = compare_wr ? '0 : count_q + 1'b1;
        compare_next = compare_wr ? i_wdata : compare_q;
        match_next   = (count_next == compare_next);
    end

    always_ff @(posedge i_clk) begin
        compare_q <= compare_next;
    end

    // Irq rises with the matching count, N+1 cycles after the write request
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            count_q <= '0;
            armed_q <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            count_q <= count_next;
            if (compare_wr) begin
                armed_q <= 1'b1;
                irq_q   <= match_next;     // Compare of 0 matches at once
            end else if (armed_q && match_next) begin
                irq_q   <= 1'b1;           // Level, held until next compare write
            end
        end
    end

    assign o_irq = irq_q;

    always_ff @(posedge i_clk) begin
        if (i_req) begin
            o_rdata <= count_rd ? count_q : '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_gnt <= 1'b0;
        end else begin
            o_gnt <= i_req;
        end
    end

endmodule

`default_nettype wire

// ==== logic/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    // ####################################################################
    // UART transmitter registers
    // ####################################################################

    localparam logic [1:0] UART_REG_DATA   = 2'd0;  // Write side
    localparam logic [1:0] UART_REG_STATUS = 2'd0;  // Read side

    localparam int UART_ST_BUSY = 0;
    localparam int UART_ST_DONE = 1;                 // Sticky, drives the irq

    // ####################################################################
    // Interval timer registers
    // ####################################################################

    localparam logic [1:0] TMR_REG_COMPARE = 2'd0;  // Write side
    localparam logic [1:0] TMR_REG_COUNT   = 2'd0;  // Read side

endpackage

`default_nettype wire

// ==== logic/system.sv ====
`default_nettype none

module system #(
    parameter int RAM_WORDS    = 256,
    parameter int CLKS_PER_BIT = 8
) (
    input  wire logic           i_clk,
    input  wire logic           i_reset,
    input  wire logic           i_bus_req,
    input  wire logic           i_bus_we,
    input  wire bus_pkg::size_e i_bus_hb,
    input  wire bus_pkg::addr_t i_bus_addr,
    input  wire bus_pkg::data_t i_bus_wdata,
    output logic                o_bus_gnt,
    output bus_pkg::data_t      o_bus_rdata,
    output logic                o_uart_tx,
    output logic                o_uart_irq,
    output logic                o_timer_irq
);
    import bus_pkg::*;

    logic  ram_req;
    logic  uart_req;
    logic  tmr_req;
    logic  ram_gnt;
    logic  uart_gnt;
    logic  tmr_gnt;
    data_t ram_rdata;
    data_t uart_rdata;
    data_t tmr_rdata;

    // ####################################################################
    // Fabric
    // ####################################################################

    bus_decode u_decode (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_bus_req    (i_bus_req),
        .i_bus_addr   (i_bus_addr),
        .i_ram_gnt    (ram_gnt),
        .i_uart_gnt   (uart_gnt),
        .i_tmr_gnt    (tmr_gnt),
        .i_ram_rdata  (ram_rdata),
        .i_uart_rdata (uart_rdata),
        .i_tmr_rdata  (tmr_rdata),
        .o_ram_req    (ram_req),
        .o_uart_req   (uart_req),
        .o_tmr_req    (tmr_req),
        .o_bus_gnt    (o_bus_gnt),
        .o_bus_rdata  (o_bus_rdata)
    );

    // ####################################################################
    // Slaves
    // ####################################################################

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_req   (ram_req),
        .i_we    (i_bus_we),
        .i_hb    (i_bus_hb),
        .i_addr  (i_bus_addr),
        .i_wdata (i_bus_wdata),
        .o_gnt   (ram_gnt),
        .o_rdata (ram_rdata)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_req   (uart_req),
        .i_we    (i_bus_we),
        .i_addr  (i_bus_addr),
        .i_wdata (i_bus_wdata),
        .o_gnt   (uart_gnt),
        .o_rdata (uart_rdata),
        .o_tx    (o_uart_tx),
        .o_irq   (o_uart_irq)
    );

    interval_timer u_timer (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_req   (tmr_req),
        .i_we    (i_bus_we),
        .i_addr  (i_bus_addr),
        .i_wdata (i_bus_wdata),
        .o_gnt   (tmr_gnt),
        .o_rdata (tmr_rdata),
        .o_irq   (o_timer_irq)
    );

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire logic               i_clk,
    input  wire logic               i_reset,
    input  wire logic               i_req,
    input  wire logic               i_we,
    input  wire bus_pkg::bus_addr_u i_addr,
    input  wire bus_pkg::data_t     i_wdata,
    output logic                    o_gnt,
    output bus_pkg::data_t          o_rdata,
    output logic                    o_tx,
    output logic                    o_irq
);
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_e;

    state_e           state_q;
    logic [CNT_W-1:0] baud_cnt_q;
    logic [2:0]       bit_idx_q;
    logic [7:0]       shift_q;
    logic             done_q;
    logic             bit_end;
    logic             data_wr;
    logic             status_rd;
    data_t            status_word;

    assign data_wr   = i_req & i_we & (i_addr.regs.reg_sel == UART_REG_DATA);
    assign status_rd = i_req & ~i_we & (i_addr.regs.reg_sel == UART_REG_STATUS);
    assign bit_end   = (baud_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    // ####################################################################
    // 8N1 serializer
    // ####################################################################

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q    <= ST_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            done_q     <= 1'b0;
        end else begin
            if (status_rd) begin
                done_q <= 1'b0;            // Read clears, new completion wins below
            end
            baud_cnt_q <= bit_end ? '0 : baud_cnt_q + 1'b1;
            case (state_q)
                ST_IDLE: begin
                    baud_cnt_q <= '0;
                    if (data_wr) begin
                        state_q <= ST_START;
                    end
                end
                ST_START: begin
                    if (bit_end) begin
                        state_q   <= ST_DATA;
                        bit_idx_q <= '0;
                    end
                end
                ST_DATA: begin
                    if (bit_end) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= ST_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == ST_IDLE && data_wr) begin
            shift_q <= i_wdata[7:0];       // Writes while busy are dropped
        end else if (state_q == ST_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_comb begin
        case (state_q)
            ST_START: o_tx = 1'b0;
            ST_DATA:  o_tx = shift_q[0];   // LSB first
            default:  o_tx = 1'b1;
        endcase
    end

    assign o_irq = done_q;

    // ####################################################################
    // Bus side
    // ####################################################################

    always_comb begin
        status_word               = '0;
        status_word[UART_ST_BUSY] = (state_q != ST_IDLE);
        status_word[UART_ST_DONE] = done_q;
    end

    always_ff @(posedge i_clk) begin
        if (i_req) begin
            o_rdata <= status_rd ? status_word : '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_gnt <= 1'b0;
        end else begin
            o_gnt <= i_req;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/bus_pkg.sv
logic/periph_pkg.sv
logic/bus_decode.sv
logic/data_ram.sv
logic/uart_tx.sv
logic/interval_timer.sv
logic/system.sv
bench/system_props.sv
bench/system_tb.sv
